// ==== verilog/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;

    typedef enum logic [2:0] {
        STATE_FETCH     = 3'd0,
        STATE_REG_READ  = 3'd1,
        STATE_EXECUTE   = 3'd2,
        STATE_MEMORY    = 3'd3,
        STATE_REG_WRITE = 3'd4,
        STATE_RESET     = 3'd7
    } state_t;

    // RV32I base opcodes
    localparam opcode_t OPCODE_OP     = 7'b0110011;
    localparam opcode_t OPCODE_OP_IMM = 7'b0010011;
    localparam opcode_t OPCODE_LUI    = 7'b0110111;
    localparam opcode_t OPCODE_AUIPC  = 7'b0010111;
    localparam opcode_t OPCODE_JAL    = 7'b1101111;
    localparam opcode_t OPCODE_JALR   = 7'b1100111;
    localparam opcode_t OPCODE_BRANCH = 7'b1100011;
    localparam opcode_t OPCODE_LOAD   = 7'b0000011;
    localparam opcode_t OPCODE_STORE  = 7'b0100011;

    localparam funct3_t F3_ADD_SUB = 3'b000;
    localparam funct3_t F3_SLL     = 3'b001;
    localparam funct3_t F3_SLT     = 3'b010;
    localparam funct3_t F3_SLTU    = 3'b011;
    localparam funct3_t F3_XOR     = 3'b100;
    localparam funct3_t F3_SRL_SRA = 3'b101;
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;

    // Branch compares
    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

    localparam word_t INITIAL_PC = 32'h0000_0000;

    localparam int RAM_WORDS  = 1024;
    localparam int RAM_ADDR_W = $clog2(RAM_WORDS);
    typedef logic [RAM_ADDR_W-1:0] ram_addr_t;

    // Output register, outside the RAM window
    localparam word_t OUT_ADDR = 32'h8000_0000;

endpackage

`default_nettype wire

// ==== verilog/program_counter.sv ====
`default_nettype none

module program_counter import cpu_pkg::*; (
    input  wire        clk_i,
    input  wire        rst_i,
    input  wire        count_i,
    input  wire        load_i,
    input  wire word_t value_i,
    output word_t      pc_o,
    output word_t      pc_inc_o
);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pc_o <= INITIAL_PC;
        end else if (count_i) begin
            pc_o <= load_i ? value_i : pc_inc_o;
        end
    end

    // Also the link value for jumps
    assign pc_inc_o = pc_o + 32'd4;

endmodule

`default_nettype wire

// ==== verilog/registers.sv ====
`default_nettype none

module registers import cpu_pkg::*; (
    input  wire            clk_i,
    input  wire            w_enable_i,
    input  wire reg_addr_t w_address_i,
    input  wire word_t     w_data_i,
    input  wire reg_addr_t r_address1_i,
    input  wire reg_addr_t r_address2_i,
    output word_t          r_out1_o,
    output word_t          r_out2_o
);

    word_t regs [32];

    always_ff @(posedge clk_i) begin
        if (w_enable_i && w_address_i != '0) begin
            regs[w_address_i] <= w_data_i;
        end
    end

    // x0 reads as zero
    assign r_out1_o = (r_address1_i == '0) ? '0 : regs[r_address1_i];
    assign r_out2_o = (r_address2_i == '0) ? '0 : regs[r_address2_i];

endmodule

`default_nettype wire

// ==== verilog/alu.sv ====
`default_nettype none

module alu import cpu_pkg::*; (
    input  wire word_t instruction_i,
    input  wire word_t op_a_i,
    input  wire word_t op_b_i,
    input  wire word_t pc_i,
    output word_t      out_o,
    output logic       take_branch_o
);

    opcode_t opcode;
    funct3_t funct3;
    word_t imm;
    word_t operand_b;
    word_t arith;
    logic [4:0] shamt;

    assign opcode = instruction_i[6:0];
    assign funct3 = instruction_i[14:12];

    // Immediate format follows the opcode
    always_comb begin
        case (opcode)
            OPCODE_STORE:
                imm = {{20{instruction_i[31]}}, instruction_i[31:25], instruction_i[11:7]};
            OPCODE_BRANCH:
                imm = {{19{instruction_i[31]}}, instruction_i[31], instruction_i[7],
                       instruction_i[30:25], instruction_i[11:8], 1'b0};
            OPCODE_LUI, OPCODE_AUIPC:
                imm = {instruction_i[31:12], 12'b0};
            OPCODE_JAL:
                imm = {{11{instruction_i[31]}}, instruction_i[31], instruction_i[19:12],
                       instruction_i[20], instruction_i[30:21], 1'b0};
            default:
                imm = {{20{instruction_i[31]}}, instruction_i[31:20]};
        endcase
    end

    assign operand_b = (opcode == OPCODE_OP || opcode == OPCODE_BRANCH) ? op_b_i : imm;
    assign shamt = operand_b[4:0];

    always_comb begin
        case (funct3)
            F3_ADD_SUB: begin
                // Only register-register ops subtract
                if (opcode == OPCODE_OP && instruction_i[30]) begin
                    arith = op_a_i - operand_b;
                end else begin
                    arith = op_a_i + operand_b;
                end
            end
            F3_SLL:  arith = op_a_i << shamt;
            F3_SLT:  arith = {31'b0, $signed(op_a_i) < $signed(operand_b)};
            F3_SLTU: arith = {31'b0, op_a_i < operand_b};
            F3_XOR:  arith = op_a_i ^ operand_b;
            F3_SRL_SRA: begin
                if (instruction_i[30]) begin
                    arith = $signed(op_a_i) >>> shamt;
                end else begin
                    arith = op_a_i >> shamt;
                end
            end
            F3_OR:   arith = op_a_i | operand_b;
            default: arith = op_a_i & operand_b;
        endcase
    end

    always_comb begin
        case (opcode)
            OPCODE_LOAD, OPCODE_STORE: out_o = op_a_i + operand_b;
            OPCODE_JAL, OPCODE_AUIPC:  out_o = pc_i + operand_b;
            OPCODE_JALR:               out_o = (op_a_i + operand_b) & ~32'd1;
            OPCODE_LUI:                out_o = operand_b;
            OPCODE_BRANCH:             out_o = pc_i + imm;
            default:                   out_o = arith;
        endcase
    end

    always_comb begin
        case (funct3)
            F3_BEQ:  take_branch_o = (op_a_i == op_b_i);
            F3_BNE:  take_branch_o = (op_a_i != op_b_i);
            F3_BLT:  take_branch_o = ($signed(op_a_i) < $signed(op_b_i));
            F3_BGE:  take_branch_o = ($signed(op_a_i) >= $signed(op_b_i));
            F3_BLTU: take_branch_o = (op_a_i < op_b_i);
            F3_BGEU: take_branch_o = (op_a_i >= op_b_i);
            default: take_branch_o = 1'b0;
        endcase
        if (opcode != OPCODE_BRANCH) begin
            take_branch_o = 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/cpu.sv ====
`default_nettype none

module cpu import cpu_pkg::*; (
    input  wire        clk_i,
    input  wire        rst_i,
    input  wire        start_i,
    input  wire word_t dat_i,
    input  wire        ack_i,
    output word_t      dat_o,
    output word_t      adr_o,
    output logic [3:0] sel_o,
    output logic       we_o,
    output logic       stb_o,
    output logic       cyc_o
);

    state_t state;
    word_t instruction;
    opcode_t opcode;

    logic pc_count;
    logic pc_load;
    word_t pc;
    word_t pc_inc;

    logic w_enable;
    word_t w_data;
    reg_addr_t w_address;
    reg_addr_t r_address1;
    reg_addr_t r_address2;
    word_t r_out1;
    word_t r_out2;

    word_t alu_out;
    logic take_branch;
    word_t alu_out_r;
    logic take_branch_r;
    word_t load_data_r;

    logic reg_w_en;
    logic mem_r_en;
    logic mem_w_en;
    logic mem_access;
    logic is_jump;
    logic is_branch;

    program_counter program_counter (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .count_i  (pc_count),
        .load_i   (pc_load),
        .value_i  (alu_out_r),
        .pc_o     (pc),
        .pc_inc_o (pc_inc)
    );

    assign opcode     = instruction[6:0];
    assign w_address  = instruction[11:7];
    assign r_address1 = instruction[19:15];
    assign r_address2 = instruction[24:20];

    registers registers (
        .clk_i        (clk_i),
        .w_enable_i   (w_enable),
        .w_address_i  (w_address),
        .w_data_i     (w_data),
        .r_address1_i (r_address1),
        .r_address2_i (r_address2),
        .r_out1_o     (r_out1),
        .r_out2_o     (r_out2)
    );

    alu alu (
        .instruction_i (instruction),
        .op_a_i        (r_out1),
        .op_b_i        (r_out2),
        .pc_i          (pc),
        .out_o         (alu_out),
        .take_branch_o (take_branch)
    );

    // Instruction class decode
    always_comb begin
        reg_w_en  = 1'b0;
        mem_r_en  = 1'b0;
        mem_w_en  = 1'b0;
        is_jump   = 1'b0;
        is_branch = 1'b0;
        case (opcode)
            OPCODE_OP, OPCODE_OP_IMM, OPCODE_LUI, OPCODE_AUIPC: reg_w_en = 1'b1;
            OPCODE_JAL, OPCODE_JALR: begin
                reg_w_en = 1'b1;
                is_jump  = 1'b1;
            end
            OPCODE_LOAD: begin
                reg_w_en = 1'b1;
                mem_r_en = 1'b1;
            end
            OPCODE_STORE:  mem_w_en  = 1'b1;
            OPCODE_BRANCH: is_branch = 1'b1;
            default: ;
        endcase
    end

    assign mem_access = mem_r_en || mem_w_en;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state <= STATE_RESET;
        end else begin
            case (state)
                STATE_RESET: if (start_i) state <= STATE_FETCH;
                STATE_FETCH: if (ack_i) state <= STATE_REG_READ;
                STATE_REG_READ: state <= STATE_EXECUTE;
                STATE_EXECUTE: state <= STATE_MEMORY;
                STATE_MEMORY: if (!mem_access || ack_i) state <= STATE_REG_WRITE;
                STATE_REG_WRITE: state <= STATE_FETCH;
                default: state <= STATE_RESET;
            endcase
        end
    end

    // Instruction and result registers
    always_ff @(posedge clk_i) begin
        if (state == STATE_FETCH && ack_i) begin
            instruction <= dat_i;
        end
        if (state == STATE_EXECUTE) begin
            alu_out_r     <= alu_out;
            take_branch_r <= take_branch;
        end
        if (state == STATE_MEMORY && mem_r_en && ack_i) begin
            load_data_r <= dat_i;
        end
    end

    always_comb begin
        cyc_o    = 1'b0;
        stb_o    = 1'b0;
        we_o     = 1'b0;
        sel_o    = 4'b1111;
        adr_o    = pc;
        dat_o    = r_out2;
        w_enable = 1'b0;
        w_data   = alu_out_r;
        pc_count = 1'b0;
        pc_load  = 1'b0;

        case (state)
            STATE_FETCH: begin
                cyc_o = 1'b1;
                stb_o = 1'b1;
            end
            STATE_MEMORY: begin
                if (mem_access) begin
                    cyc_o = 1'b1;
                    stb_o = 1'b1;
                    we_o  = mem_w_en;
                    adr_o = alu_out_r;
                end
            end
            STATE_REG_WRITE: begin
                w_enable = reg_w_en;
                if (mem_r_en) begin
                    w_data = load_data_r;
                end else if (is_jump) begin
                    w_data = pc_inc;
                end
                // Target sits in alu_out_r for jumps and branches
                pc_count = 1'b1;
                pc_load  = is_jump || (is_branch && take_branch_r);
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/wb_mem_io.sv ====
`default_nettype none

module wb_mem_io import cpu_pkg::*; (
    input  wire            clk_i,
    input  wire            rst_i,
    input  wire            cyc_i,
    input  wire            stb_i,
    input  wire            we_i,
    input  wire word_t     adr_i,
    input  wire [3:0]      sel_i,
    input  wire word_t     dat_i,
    input  wire            load_stb_i,
    input  wire ram_addr_t load_addr_i,
    input  wire word_t     load_data_i,
    output word_t          dat_o,
    output logic           ack_o,
    output logic           out_stb_o,
    output word_t          out_data_o
);

    word_t ram [RAM_WORDS];
    ram_addr_t ram_index;
    logic is_out;
    logic served;
    logic access;

    assign ram_index = adr_i[RAM_ADDR_W+1:2];
    assign is_out    = (adr_i == OUT_ADDR);

    // New request that has not been acknowledged yet
    assign access = cyc_i && stb_i && !ack_o && !served;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ack_o     <= 1'b0;
            served    <= 1'b0;
            out_stb_o <= 1'b0;
        end else begin
            ack_o     <= access;
            served    <= stb_i && (served || ack_o);
            out_stb_o <= access && we_i && is_out;
        end
    end

    always_ff @(posedge clk_i) begin
        if (access && we_i && is_out) begin
            out_data_o <= dat_i;
        end
        if (access && !we_i) begin
            dat_o <= is_out ? out_data_o : ram[ram_index];
        end
    end

    // Loader has the port while the core is idle
    always_ff @(posedge clk_i) begin
        if (load_stb_i) begin
            ram[load_addr_i] <= load_data_i;
        end else if (access && we_i && !is_out) begin
            for (int b = 0; b < 4; b++) begin
                if (sel_i[b]) begin
                    ram[ram_index][8*b +: 8] <= dat_i[8*b +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/cpu_system.sv ====
`default_nettype none

module cpu_system import cpu_pkg::*; (
    input  wire            clk_i,
    input  wire            rst_i,
    input  wire            start_i,
    input  wire            load_stb_i,
    input  wire ram_addr_t load_addr_i,
    input  wire word_t     load_data_i,
    output wire            out_stb_o,
    output word_t          out_data_o
);

    word_t cpu_dat_o;
    word_t mem_dat_o;
    word_t adr;
    logic [3:0] sel;
    logic we;
    logic stb;
    logic cyc;
    logic ack;

    cpu cpu (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .start_i (start_i),
        .dat_i   (mem_dat_o),
        .ack_i   (ack),
        .dat_o   (cpu_dat_o),
        .adr_o   (adr),
        .sel_o   (sel),
        .we_o    (we),
        .stb_o   (stb),
        .cyc_o   (cyc)
    );

    wb_mem_io wb_mem_io (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .cyc_i       (cyc),
        .stb_i       (stb),
        .we_i        (we),
        .adr_i       (adr),
        .sel_i       (sel),
        .dat_i       (cpu_dat_o),
        .load_stb_i  (load_stb_i),
        .load_addr_i (load_addr_i),
        .load_data_i (load_data_i),
        .dat_o       (mem_dat_o),
        .ack_o       (ack),
        .out_stb_o   (out_stb_o),
        .out_data_o  (out_data_o)
    );

endmodule

`default_nettype wire

// ==== tests/cpu_props.sv ====
`default_nettype none

module cpu_props import cpu_pkg::*; (
    input wire         clk_i,
    input wire         rst_i,
    input wire state_t state_i,
    input wire         cyc_i,
    input wire         stb_i,
    input wire         we_i,
    input wire word_t  adr_i,
    input wire word_t  dat_i,
    input wire         ack_i,
    input wire         out_stb_i
);

    // Count of failed properties
    int failures = 0;

    stb_needs_cyc: assert property (@(posedge clk_i) disable iff (rst_i)
        stb_i |-> cyc_i)
        else begin
            failures++;
            $error("stb raised without cyc");
        end

    idle_no_request: assert property (@(posedge clk_i) disable iff (rst_i)
        state_i == STATE_RESET |-> !cyc_i && !stb_i)
        else begin
            failures++;
            $error("bus request while the core is idle");
        end

    // Master keeps the cycle unchanged until the slave answers
    request_held: assert property (@(posedge clk_i) disable iff (rst_i)
        stb_i && !ack_i |=> stb_i && $stable(adr_i) && $stable(we_i)
                            && (!we_i || $stable(dat_i)))
        else begin
            failures++;
            $error("bus request changed before ack");
        end

    out_stb_single: assert property (@(posedge clk_i) disable iff (rst_i)
        out_stb_i |=> !out_stb_i)
        else begin
            failures++;
            $error("output strobe high for two cycles");
        end

endmodule

bind cpu_system cpu_props props_i (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .state_i   (cpu.state),
    .cyc_i     (cyc),
    .stb_i     (stb),
    .we_i      (we),
    .adr_i     (adr),
    .dat_i     (cpu_dat_o),
    .ack_i     (ack),
    .out_stb_i (out_stb_o)
);

`default_nettype wire

// ==== tests/cpu_system_tb.sv ====
`default_nettype none

module cpu_system_tb import cpu_pkg::*; ();

    localparam int CASE_WORDS       = 512;
    localparam int RESET_CYCLES     = 5;
    localparam int GRACE_CYCLES     = 20;
    localparam int CYCLES_PER_INSTR = 6;
    localparam int MARGIN_CYCLES    = 200;

    logic      clk;
    logic      rst;
    logic      start;
    logic      load_stb;
    ram_addr_t load_addr;
    word_t     load_data;
    wire       out_stb;
    word_t     out_data;

    word_t cases [CASE_WORDS];
    word_t expected_q [$];
    word_t next_expected;

    int value_errors = 0;
    int extra_errors = 0;
    int setup_errors = 0;
    int cycles = 0;
    int cycle_limit = 0;

    cpu_system dut_i (
        .clk_i       (clk),
        .rst_i       (rst),
        .start_i     (start),
        .load_stb_i  (load_stb),
        .load_addr_i (load_addr),
        .load_data_i (load_data),
        .out_stb_o   (out_stb),
        .out_data_o  (out_data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic apply_reset();
        rst <= 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    endtask

    task automatic load_program(input int base, input int count);
        for (int i = 0; i < count; i++) begin
            load_stb  <= 1'b1;
            load_addr <= ram_addr_t'(i);
            load_data <= cases[base + i];
            @(posedge clk);
        end
        load_stb <= 1'b0;
    endtask

    task automatic pulse_start();
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
    endtask

    // Drain the expected values, then watch a while for stray outputs
    task automatic wait_for_outputs();
        while (expected_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (GRACE_CYCLES) @(posedge clk);
    endtask

    task automatic report_counts();
        $display("Errors: %0d wrong values, %0d extra outputs, %0d setup, %0d protocol",
                 value_errors, extra_errors, setup_errors, dut_i.props_i.failures);
    endtask

    // Outputs are registered, so mid-cycle they are settled
    always @(negedge clk) begin
        if (out_stb) begin
            assert (expected_q.size() > 0)
            else begin
                extra_errors++;
                $display("Unexpected extra output %h at time %0t", out_data, $time);
            end
            if (expected_q.size() > 0) begin
                next_expected = expected_q.pop_front();
                assert (out_data == next_expected)
                else begin
                    value_errors++;
                    $display("ERR %0t: output %h, expected %h",
                             $time, out_data, next_expected);
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout after %0d cycles, expected outputs never arrived", cycles);
            report_counts();
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    initial begin
        int idx;
        int n_words;
        int n_out;
        int runs;
        int programs;

        rst       = 1'b1;
        start     = 1'b0;
        load_stb  = 1'b0;
        load_addr = '0;
        load_data = '0;
        for (int i = 0; i < CASE_WORDS; i++) begin
            cases[i] = '0;
        end
        $readmemh("tests/cpu_cases.txt", cases);

        // Cycle budget over all programs and runs
        idx = 0;
        programs = 0;
        cycle_limit = MARGIN_CYCLES;
        while (idx < CASE_WORDS - 4 && cases[idx] != 0) begin
            n_words = cases[idx];
            runs    = cases[idx + 1];
            n_out   = cases[idx + 3 + n_words];
            cycle_limit += n_words + runs * (RESET_CYCLES + 2 + GRACE_CYCLES
                           + CYCLES_PER_INSTR * int'(cases[idx + 2]));
            idx += 4 + n_words + n_out;
            programs++;
        end
        assert (programs > 0)
        else begin
            setup_errors++;
            $display("No programs could be read from tests/cpu_cases.txt");
        end

        @(posedge clk);
        idx = 0;
        for (int p = 0; p < programs; p++) begin
            n_words = cases[idx];
            runs    = cases[idx + 1];
            n_out   = cases[idx + 3 + n_words];
            assert (n_words <= RAM_WORDS)
            else begin
                setup_errors++;
                $display("Program %0d does not fit in the RAM", p);
            end
            if (n_words <= RAM_WORDS) begin
                // Later runs restart from the program already in RAM
                for (int r = 0; r < runs; r++) begin
                    apply_reset();
                    if (r == 0) begin
                        load_program(idx + 3, n_words);
                    end
                    for (int k = 0; k < n_out; k++) begin
                        expected_q.push_back(cases[idx + 4 + n_words + k]);
                    end
                    pulse_start();
                    wait_for_outputs();
                end
            end
            idx += 4 + n_words + n_out;
        end

        report_counts();
        if (value_errors + extra_errors + setup_errors + dut_i.props_i.failures == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
verilog/cpu_pkg.sv
verilog/program_counter.sv
verilog/registers.sv
verilog/alu.sv
verilog/cpu.sv
verilog/wb_mem_io.sv
verilog/cpu_system.sv
tests/cpu_props.sv
tests/cpu_system_tb.sv

// ==== tests/cpu_cases.txt ====
// Per program: word count, run count, instruction bound, then the program words,
// then the expected output count and the expected output values. A word count of 0 ends.
16 1 1E // arithmetic
80000FB7 00700093 FFD00113 002081B3 003FA023 40208233 004FA023 0020C2B3
005FA023 00409313 006FA023 40115393 007FA023 01C15413 008FA023 001124B3
009FA023 00113533 00AFA023 123455B7 00BFA023 0000006F
9 00000004 0000000A FFFFFFFA 00000070 FFFFFFFE 0000000F 00000001 00000000 12345000
B 1 F // memory round trip
80000FB7 12300093 FFF00113 40000513 00152023 00252223 00052183 00452203
003FA023 004FA023 0000006F
2 00000123 FFFFFFFF
19 1 3C // branch loop and all compares
80000FB7 00000093 00100113 00B00193 FFF00413 00000313 002080B3 00110113 FE311CE3
001FA023 00208663 05A00293 005FA023 00244463 00130313 00245463 00430313 00246463
00830313 00247463 01030313 00310463 02030313 006FA023 0000006F
3 00000037 0000005A 0000000C
C 1 F // jumps and AUIPC
80000FB7 008000EF 000FA023 001FA023 02000113 000101E7 000FA023 000FA023
003FA023 00001217 004FA023 0000006F
3 00000008 00000018 00001024
8 2 A // x0 writes, run twice
80000FB7 00500013 000FA023 07700093 00108033 000FA023 001FA023 0000006F
3 00000000 00000000 00000077
0
